// ==== elevator_pkg.sv ====
// Elevator request definitions
package elevator_pkg;

    ////////////////////
    // Building size
    ////////////////////

    // Floors are numbered from 0 at the lobby
    localparam int num_floors = 11;

    // Pending requests held before the dispatcher takes them
    localparam int default_queue_depth = 16;

    ////////////////////
    // Types
    ////////////////////

    // Zero-based floor number
    typedef logic [3:0] floor_t;

    // One bit per floor for button and lamp vectors
    typedef logic [num_floors-1:0] floor_mask_t;

    // One queued floor request
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } floor_request_t;

    // Car stands still at its target floor
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } floor_arrival_t;

endpackage

// ==== floor_request_capture.sv ====
// Button capture and lamps
module floor_request_capture (
    input  logic                         clock,
    input  logic                         reset_n,
    input  elevator_pkg::floor_mask_t    floor_call_buttons,
    input  elevator_pkg::floor_mask_t    panel_buttons,
    input  logic                         emergency_button,
    input  logic                         power_switch,
    input  elevator_pkg::floor_t         current_floor,
    input  logic                         full,
    input  elevator_pkg::floor_arrival_t arrival,
    output elevator_pkg::floor_request_t request,
    output elevator_pkg::floor_mask_t    call_button_lights,
    output elevator_pkg::floor_mask_t    panel_button_lights
);

    logic                      enabled;
    logic                      take_panel;
    logic                      take_call;
    elevator_pkg::floor_t      pick;
    elevator_pkg::floor_mask_t lit;
    elevator_pkg::floor_mask_t current_mask;
    elevator_pkg::floor_mask_t clear_mask;
    elevator_pkg::floor_mask_t panel_free;
    elevator_pkg::floor_mask_t call_free;
    elevator_pkg::floor_mask_t panel_join;
    elevator_pkg::floor_mask_t call_join;
    elevator_pkg::floor_mask_t panel_set;
    elevator_pkg::floor_mask_t call_set;

    // Lowest set bit of a floor mask
    function automatic elevator_pkg::floor_t lowest_floor(input elevator_pkg::floor_mask_t mask);
        elevator_pkg::floor_t idx;
        idx = '0;
        for (int i = elevator_pkg::num_floors - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = elevator_pkg::floor_t'(i);
            end
        end
        return idx;
    endfunction

    ////////////////////
    // Press selection
    ////////////////////

    always_comb begin
        enabled      = power_switch && !emergency_button && !full;
        lit          = panel_button_lights | call_button_lights;
        current_mask = elevator_pkg::floor_mask_t'(1) << current_floor;
        clear_mask   = arrival.valid ? (elevator_pkg::floor_mask_t'(1) << arrival.floor) : '0;

        // Floors not yet queued, excluding where the car stands
        panel_free = panel_buttons & ~lit & ~current_mask;
        call_free  = floor_call_buttons & ~lit & ~current_mask;

        // Already queued via the other panel, only the lamp joins in
        panel_join = panel_buttons & ~panel_button_lights & call_button_lights & ~current_mask;
        call_join  = floor_call_buttons & ~call_button_lights & panel_button_lights & ~current_mask;

        // Panel first, then hall calls
        take_panel = enabled && (|panel_free);
        take_call  = enabled && !(|panel_free) && (|call_free);
        pick       = take_panel ? lowest_floor(panel_free) : lowest_floor(call_free);

        panel_set = '0;
        call_set  = '0;
        if (take_panel) begin
            panel_set = elevator_pkg::floor_mask_t'(1) << pick;
        end
        if (take_call) begin
            call_set = elevator_pkg::floor_mask_t'(1) << pick;
        end
        if (enabled) begin
            panel_set = panel_set | panel_join;
            call_set  = call_set | call_join;
        end
    end

    ////////////////////
    // Lamps and request
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
            request             <= '0;
        end else begin
            // Arrival wins over a new press on the same floor
            panel_button_lights <= (panel_button_lights | panel_set) & ~clear_mask;
            call_button_lights  <= (call_button_lights | call_set) & ~clear_mask;
            request.valid       <= take_panel || take_call;
            request.floor       <= pick;
        end
    end

    // A request is only issued when the queue had room on the sampling edge
    assert property (@(posedge clock) disable iff (!reset_n)
        request.valid |-> !$past(full));

endmodule

// ==== floor_request_queue.sv ====
// Floor request FIFO
module floor_request_queue #(
    parameter int QUEUE_DEPTH = elevator_pkg::default_queue_depth
) (
    input  logic                         clock,
    input  logic                         reset_n,
    input  elevator_pkg::floor_request_t request,
    input  logic                         pop,
    output elevator_pkg::floor_t         head,
    output logic                         empty,
    output logic                         full
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    elevator_pkg::floor_t mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);

    // The request in flight already holds a slot, so full looks one entry ahead
    assign full = (count == CNT_W'(QUEUE_DEPTH)) ||
                  (request.valid && count == CNT_W'(QUEUE_DEPTH - 1));

    // Storage
    always_ff @(posedge clock) begin
        if (request.valid) begin
            mem[wr_ptr] <= request.floor;
        end
    end

    ////////////////////
    // Pointers and count
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (request.valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({request.valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Capture must never overrun the storage
    assert property (@(posedge clock) disable iff (!reset_n)
        request.valid |-> count != CNT_W'(QUEUE_DEPTH));

    // Dispatcher only takes a floor that is there
    assert property (@(posedge clock) disable iff (!reset_n)
        pop |-> !empty);

endmodule

// ==== floor_dispatcher.sv ====
// Target floor dispatcher
module floor_dispatcher (
    input  logic                         clock,
    input  logic                         reset_n,
    input  elevator_pkg::floor_t         head,
    input  logic                         empty,
    output logic                         pop,
    input  logic                         emergency_button,
    input  logic                         power_switch,
    input  elevator_pkg::floor_t         current_floor,
    input  logic                         elevator_moving,
    output elevator_pkg::floor_t         floor_selector,
    output logic                         direction_selector,
    output logic                         activate_elevator,
    output elevator_pkg::floor_arrival_t arrival
);

    logic                 target_valid;
    elevator_pkg::floor_t target_floor;
    logic                 enabled;

    // Take the next floor only when idle
    assign pop = !target_valid && !empty;

    ////////////////////
    // Target register
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_valid <= 1'b0;
            target_floor <= '0;
        end else if (pop) begin
            target_valid <= 1'b1;
            target_floor <= head;
        end else if (arrival.valid) begin
            target_valid <= 1'b0;
        end
    end

    ////////////////////
    // Car outputs
    ////////////////////

    always_comb begin
        enabled            = power_switch && !emergency_button;
        floor_selector     = target_floor;
        direction_selector = (target_floor > current_floor);
        activate_elevator  = target_valid && enabled && !elevator_moving &&
                             (target_floor != current_floor);

        // Also fires at once for a popped floor where the car already stands
        arrival.valid = target_valid && !elevator_moving && (current_floor == target_floor);
        arrival.floor = target_floor;
    end

    // A queued floor always lies inside the building
    assert property (@(posedge clock) disable iff (!reset_n)
        target_valid |-> target_floor < elevator_pkg::floor_t'(elevator_pkg::num_floors));

endmodule

// ==== floor_logic_top.sv ====
// Floor request controller
module floor_logic_top #(
    parameter int QUEUE_DEPTH = elevator_pkg::default_queue_depth
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      emergency_button,
    input  logic                      power_switch,
    input  elevator_pkg::floor_t      current_floor,
    input  logic                      elevator_moving,
    output elevator_pkg::floor_t      floor_selector,
    output logic                      direction_selector,
    output logic                      activate_elevator,
    output elevator_pkg::floor_mask_t call_button_lights,
    output elevator_pkg::floor_mask_t panel_button_lights
);

    elevator_pkg::floor_request_t request;
    elevator_pkg::floor_arrival_t arrival;
    elevator_pkg::floor_t         head;
    logic                         empty;
    logic                         full;
    logic                         pop;

    ////////////////////
    // Button side
    ////////////////////

    floor_request_capture u_capture (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .emergency_button    (emergency_button),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .full                (full),
        .arrival             (arrival),
        .request             (request),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    floor_request_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clock   (clock),
        .reset_n (reset_n),
        .request (request),
        .pop     (pop),
        .head    (head),
        .empty   (empty),
        .full    (full)
    );

    ////////////////////
    // Car side
    ////////////////////

    floor_dispatcher u_dispatcher (
        .clock              (clock),
        .reset_n            (reset_n),
        .head               (head),
        .empty              (empty),
        .pop                (pop),
        .emergency_button   (emergency_button),
        .power_switch       (power_switch),
        .current_floor      (current_floor),
        .elevator_moving    (elevator_moving),
        .floor_selector     (floor_selector),
        .direction_selector (direction_selector),
        .activate_elevator  (activate_elevator),
        .arrival            (arrival)
    );

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and reset
module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic reset_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // Release just after an edge, like every other testbench input
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset_n = 1'b1;
    end

endmodule

// ==== tb_floor_logic.sv ====
// Floor request controller testbench
module tb_floor_logic;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS       = 7;
    localparam int CYCLES_PER_TEST = 60;

    typedef struct packed {
        elevator_pkg::floor_mask_t panel;
        elevator_pkg::floor_mask_t call;
        logic                      emergency;
        logic                      power;
        logic [7:0]                cycles;
    } press_step_t;

    typedef struct packed {
        elevator_pkg::floor_t       start;
        logic                       hold_car;
        elevator_pkg::floor_mask_t  held_lamps;
        logic                       want_both;
        logic [2:0]                 num_steps;
        press_step_t [0:3]          steps;
        logic [3:0]                 num_visits;
        elevator_pkg::floor_t [0:5] visits;
    } test_row_t;

    // What the monitor saw during one row
    typedef struct packed {
        logic                 seen_act;
        logic [31:0]          act_cycle;
        logic                 act_dir;
        elevator_pkg::floor_t act_floor;
        logic                 seen_lamp;
        logic                 seen_both;
        logic                 bad_lamp;
        logic                 bad_act;
    } row_record_t;

    logic                      clock;
    logic                      reset_n;
    elevator_pkg::floor_mask_t floor_call_buttons;
    elevator_pkg::floor_mask_t panel_buttons;
    logic                      emergency_button;
    logic                      power_switch;
    elevator_pkg::floor_t      current_floor = '0;
    logic                      car_moving = 1'b0;
    logic                      hold_car;
    logic                      elevator_moving;
    elevator_pkg::floor_t      floor_selector;
    logic                      direction_selector;
    logic                      activate_elevator;
    elevator_pkg::floor_mask_t call_button_lights;
    elevator_pkg::floor_mask_t panel_button_lights;

    test_row_t                 table_rows [NUM_TESTS];
    string                     test_names [NUM_TESTS];
    int                        num_rows = 0;
    int                        cycle = 0;
    int                        press_cycle = 0;
    int                        row_seq = 0;
    int                        home_seq = 0;
    int                        placed_seq = 0;
    elevator_pkg::floor_t      home_floor = '0;
    logic [31:0]               rng = 32'h93dae5f2;
    int                        errors = 0;
    int                        passed = 0;
    int                        failed = 0;
    int                        rec_row = 0;
    row_record_t               rec = '0;
    int                        visit_count = 0;
    elevator_pkg::floor_t      visit_log [8];
    elevator_pkg::floor_mask_t prev_lamps = '0;
    logic                      was_disabled = 1'b1;

    assign elevator_moving = car_moving || hold_car;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(3)) u_clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    floor_logic_top #(.QUEUE_DEPTH(4)) UUT (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .emergency_button    (emergency_button),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .elevator_moving     (elevator_moving),
        .floor_selector      (floor_selector),
        .direction_selector  (direction_selector),
        .activate_elevator   (activate_elevator),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic elevator_pkg::floor_mask_t bit_of(input int f);
        return elevator_pkg::floor_mask_t'(1) << f;
    endfunction

    function automatic press_step_t make_step(input elevator_pkg::floor_mask_t panel,
                                              input elevator_pkg::floor_mask_t call,
                                              input logic emergency, input logic power,
                                              input logic [7:0] cycles);
        return {panel, call, emergency, power, cycles};
    endfunction

    task automatic add_row(input string name, input elevator_pkg::floor_t start,
                           input logic hold, input elevator_pkg::floor_mask_t held,
                           input logic both, input logic [2:0] num_steps,
                           input press_step_t s0, input press_step_t s1, input press_step_t s2,
                           input logic [3:0] num_visits,
                           input elevator_pkg::floor_t [0:5] visits);
        test_names[num_rows] = name;
        table_rows[num_rows] = {start, hold, held, both, num_steps, s0, s1, s2,
                                press_step_t'(0), num_visits, visits};
        num_rows++;
    endtask

    task automatic check_value(input string test, input string what,
                               input int expected, input int actual);
        if (expected !== actual) begin
            $display("FAIL %s %s expected %0d actual %0d", test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic apply_step(input press_step_t step);
        panel_buttons      = step.panel;
        floor_call_buttons = step.call;
        emergency_button   = step.emergency;
        power_switch       = step.power;
        repeat (int'(step.cycles)) @(posedge clock);
        #2;
    endtask

    ////////////////////
    // Car model and monitor
    ////////////////////

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // Travels to floor_selector for 2 to 9 cycles whenever activated
    always begin : car_model
        elevator_pkg::floor_t dest;
        int                   travel;
        @(negedge clock);
        if (home_seq != placed_seq) begin
            placed_seq = home_seq;
            @(posedge clock);
            #2;
            current_floor = home_floor;
        end else if (activate_elevator) begin
            dest   = floor_selector;
            rng    = xorshift(rng);
            travel = 2 + int'(rng[2:0]);
            @(posedge clock);
            #2;
            car_moving = 1'b1;
            repeat (travel) @(posedge clock);
            #2;
            current_floor = dest;
            car_moving    = 1'b0;
        end
    end

    // A lamp going dark marks a visited floor
    always @(negedge clock) begin : lamp_monitor
        elevator_pkg::floor_mask_t lamps;
        lamps = panel_button_lights | call_button_lights;
        if (rec_row != row_seq) begin
            rec_row     = row_seq;
            rec         = '0;
            visit_count = 0;
        end
        for (int i = 0; i < elevator_pkg::num_floors; i++) begin
            if (prev_lamps[i] && !lamps[i] && visit_count < 8) begin
                visit_log[visit_count] = elevator_pkg::floor_t'(i);
                visit_count++;
            end
        end
        if ((lamps & ~prev_lamps) != '0) begin
            rec.seen_lamp = 1'b1;
            rec.bad_lamp  = rec.bad_lamp || was_disabled;
        end
        if ((panel_button_lights & call_button_lights) != '0) begin
            rec.seen_both = 1'b1;
        end
        if (activate_elevator && (!power_switch || emergency_button)) begin
            rec.bad_act = 1'b1;
        end
        if (activate_elevator && !rec.seen_act) begin
            rec.seen_act  = 1'b1;
            rec.act_cycle = cycle;
            rec.act_dir   = direction_selector;
            rec.act_floor = floor_selector;
        end
        prev_lamps   = lamps;
        was_disabled = !power_switch || emergency_button;
    end

    ////////////////////
    // Test sequence
    ////////////////////

    task automatic run_test(input int t);
        test_row_t row;
        int        errors_before;
        row           = table_rows[t];
        errors_before = errors;
        row_seq++;
        home_floor = row.start;
        home_seq++;
        hold_car = row.hold_car;
        repeat (3) @(posedge clock);
        #2;
        press_cycle = cycle + 1;
        for (int s = 0; s < int'(row.num_steps); s++) begin
            apply_step(row.steps[s]);
            // Queue stays full while the car is held
            if (s == 0 && row.hold_car) begin
                check_value(test_names[t], "lamps while held", int'(row.held_lamps),
                            int'(panel_button_lights | call_button_lights));
                hold_car = 1'b0;
            end
        end
        apply_step(make_step('0, '0, 1'b0, 1'b1, 8'd1));
        @(negedge clock);
        while (((panel_button_lights | call_button_lights) != '0) || elevator_moving) begin
            @(negedge clock);
        end
        repeat (2) @(posedge clock);
        #2;

        check_value(test_names[t], "visit count", int'(row.num_visits), visit_count);
        for (int i = 0; i < int'(row.num_visits) && i < visit_count; i++) begin
            check_value(test_names[t], $sformatf("visit %0d", i), int'(row.visits[i]),
                        int'(visit_log[i]));
        end
        check_value(test_names[t], "lamp lit while disabled", 0, int'(rec.bad_lamp));
        check_value(test_names[t], "activate while disabled", 0, int'(rec.bad_act));
        if (row.num_visits == '0) begin
            check_value(test_names[t], "activate seen", 0, int'(rec.seen_act));
            check_value(test_names[t], "lamp seen", 0, int'(rec.seen_lamp));
        end else if (!row.hold_car && row.steps[0].power && !row.steps[0].emergency) begin
            check_value(test_names[t], "activate seen", 1, int'(rec.seen_act));
            check_value(test_names[t], "activate latency", 2, int'(rec.act_cycle) - press_cycle);
            check_value(test_names[t], "first target", int'(row.visits[0]), int'(rec.act_floor));
            check_value(test_names[t], "direction up", int'(row.visits[0] > row.start),
                        int'(rec.act_dir));
        end
        if (row.want_both) begin
            check_value(test_names[t], "both lamps lit", 1, int'(rec.seen_both));
        end

        if (errors == errors_before) begin
            passed++;
            $display("test %s passed", test_names[t]);
        end else begin
            failed++;
            $display("test %s failed", test_names[t]);
        end
    endtask

    initial begin
        panel_buttons      = '0;
        floor_call_buttons = '0;
        emergency_button   = 1'b0;
        power_switch       = 1'b1;
        hold_car           = 1'b0;

        add_row("single_up", 4'd2, 1'b0, '0, 1'b0, 3'd1,
                make_step(bit_of(7), '0, 1'b0, 1'b1, 8'd2), '0, '0, 4'd1, {4'd7, 20'd0});
        add_row("single_down", 4'd9, 1'b0, '0, 1'b0, 3'd1,
                make_step('0, bit_of(3), 1'b0, 1'b1, 8'd2), '0, '0, 4'd1, {4'd3, 20'd0});
        add_row("current_floor", 4'd4, 1'b0, '0, 1'b0, 3'd1,
                make_step(bit_of(4), bit_of(4), 1'b0, 1'b1, 8'd3), '0, '0, 4'd0, '0);
        // Same-cycle presses go panel first, then lowest floor
        add_row("press_order", 4'd0, 1'b0, '0, 1'b0, 3'd3,
                make_step(bit_of(6), '0, 1'b0, 1'b1, 8'd2),
                make_step('0, bit_of(2), 1'b0, 1'b1, 8'd2),
                make_step(bit_of(1) | bit_of(8), bit_of(3), 1'b0, 1'b1, 8'd4),
                4'd5, {4'd6, 4'd2, 4'd1, 4'd8, 4'd3, 4'd0});
        add_row("same_floor", 4'd1, 1'b0, '0, 1'b1, 3'd1,
                make_step(bit_of(5), bit_of(5), 1'b0, 1'b1, 8'd3), '0, '0, 4'd1, {4'd5, 20'd0});
        add_row("emergency_power", 4'd3, 1'b0, '0, 1'b0, 3'd3,
                make_step(bit_of(8), '0, 1'b1, 1'b1, 8'd3),
                make_step(bit_of(2), bit_of(0), 1'b0, 1'b0, 8'd3),
                make_step(bit_of(6), '0, 1'b0, 1'b1, 8'd2), 4'd1, {4'd6, 20'd0});
        // Target plus four queued, floor 10 waits for a free slot
        add_row("queue_full", 4'd0, 1'b1,
                bit_of(1) | bit_of(3) | bit_of(5) | bit_of(7) | bit_of(9), 1'b0, 3'd2,
                make_step(bit_of(1) | bit_of(3) | bit_of(5) | bit_of(7) | bit_of(9) | bit_of(10),
                          '0, 1'b0, 1'b1, 8'd10),
                make_step(bit_of(10), '0, 1'b0, 1'b1, 8'd24), '0,
                4'd6, {4'd1, 4'd3, 4'd5, 4'd7, 4'd9, 4'd10});

        @(posedge reset_n);
        @(posedge clock);
        #2;
        for (int t = 0; t < num_rows; t++) begin
            run_test(t);
        end
        $display("tests %0d, passed %0d, failed %0d, failed checks %0d",
                 num_rows, passed, failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clock);
        $display("Timeout: the tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== filelist.f ====
elevator_pkg.sv
floor_request_capture.sv
floor_request_queue.sv
floor_dispatcher.sv
floor_logic_top.sv
tb_clock_gen.sv
tb_floor_logic.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_floor_logic -f filelist.f &&
./obj_dir/Vtb_floor_logic | tee /dev/stderr | grep -q "^=== PASS ===$" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
